// ==== flist.f ====
common/tlb_pkg.sv
tlb/tlb_dual_ram.sv
tlb/tlb_ram.sv
source/tlb_cmd_decode.sv
source/tlb_translate.sv
source/mmu_tlb_top.sv
dv/mmu_tlb_chk.sv
dv/tb_mmu_tlb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator and run; pass only when the pass message is printed.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_mmu_tlb -f flist.f -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "Done: no errors" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// ==== dv/tb_mmu_tlb.sv ====
// Testbench for the MMU TLB with random stimulus and a 64-entry reference model.
`timescale 1ns/1ns
`default_nettype none

module tb_mmu_tlb import tlb_pkg::*; ;

    localparam int random_low = 8;
    localparam int timeout    = 40;

    logic               clk;
    logic               rst_n;
    logic               cmd_valid;
    tlb_cmd_t           cmd;
    logic               data_start;
    logic [31:0]        data_vaddr;
    logic               data_store;
    logic               fetch_start;
    logic [31:0]        fetch_vaddr;
    logic               read_valid;
    tlb_entry_t         read_entry;
    logic               probe_done;
    logic               probe_hit;
    logic [index_w-1:0] probe_index;
    logic               busy;
    logic               data_done;
    tlb_result_t        data_result;
    logic               fetch_done;
    tlb_result_t        fetch_result;

    tlb_entry_t         model [64];
    logic [index_w-1:0] model_random;
    logic [asid_w-1:0]  model_asid;
    integer             seed;
    int                 errors;
    int                 checks;
    int                 tests;
    int                 errors_before;

    mmu_tlb_top #(.random_low(random_low)) dut (
        .clk(clk), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd(cmd),
        .data_start(data_start), .data_vaddr(data_vaddr), .data_store(data_store),
        .fetch_start(fetch_start), .fetch_vaddr(fetch_vaddr),
        .read_valid(read_valid), .read_entry(read_entry), .probe_done(probe_done),
        .probe_hit(probe_hit), .probe_index(probe_index), .busy(busy),
        .data_done(data_done), .data_result(data_result),
        .fetch_done(fetch_done), .fetch_result(fetch_result)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic tick();
        @(posedge clk);
        #1;  // Drive and sample just after the edge.
    endtask

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic abort_timeout(input string what);
        $display("Timeout waiting for %s.", what);
        $display("Done: errors found");
        $finish;
    endtask

    // Low vpn bits carry the index, so written vpns stay unique.
    task automatic gen_entry(input int idx, output tlb_entry_t e);
        e.g    = ($random(seed) & 3) == 0;
        e.v    = ($random(seed) & 7) != 0;
        e.d    = 1'($random(seed) & 1);
        e.n    = 1'($random(seed) & 1);
        e.asid = 6'($random(seed) & 3);
        e.pfn  = 20'($random(seed));
        e.vpn  = {1'b0, 13'($random(seed)), 6'(idx)};
    endtask

    task automatic send_cmd(input tlb_cmd_e op, input int idx, input tlb_entry_t e);
        cmd.op    = op;
        cmd.index = 6'(idx);
        cmd.entry = e;
        cmd_valid = 1'b1;
        tick();
        cmd_valid = 1'b0;
        cmd.op    = tlb_nop;
    endtask

    task automatic read_check(input string name, input int idx);
        send_cmd(tlb_read, idx, '0);
        compare({name, " read_valid"}, 64'(1), 64'(read_valid));
        compare(name, 64'(model[idx]), 64'(read_entry));
    endtask

    // Translation rules: refill, invalid, modified, else pfn and offset.
    function automatic tlb_result_t expect_result(input logic [19:0] vpn,
                                                  input logic [11:0] offset,
                                                  input logic store);
        tlb_result_t r;
        int          hit;
        r   = '0;
        hit = -1;
        for (int i = 0; i < 64; i++) begin
            if (model[i].vpn == vpn && (model[i].g || model[i].asid == model_asid))
                hit = i;
        end
        if (hit < 0)
            r.exc = exc_refill;
        else if (!model[hit].v)
            r.exc = exc_invalid;
        else if (store && !model[hit].d)
            r.exc = exc_modified;
        else begin
            r.paddr    = {model[hit].pfn, offset};
            r.uncached = model[hit].n;
        end
        return r;
    endfunction

    task automatic probe_check(input logic [19:0] vpn, input logic [5:0] asid,
                               input logic exp_hit, input int exp_idx);
        tlb_entry_t e;
        int         n;
        e          = '0;
        e.vpn      = vpn;
        e.asid     = asid;
        model_asid = asid;  // Probe loads the ASID.
        send_cmd(tlb_probe, 0, e);
        n = 0;
        while (!probe_done) begin
            if (n >= timeout)
                abort_timeout("probe_done");
            compare("probe busy", 64'(1), 64'(busy));
            tick();
            n++;
        end
        compare("probe hit", 64'(exp_hit), 64'(probe_hit));
        if (exp_hit)
            compare("probe index", 64'(exp_idx), 64'(probe_index));
    endtask

    function automatic logic [19:0] pick_vpn(input int r);
        if (r % 4 == 0)
            return {1'b1, 19'(r)};  // Never written.
        return model[(r >> 2) & 63].vpn;
    endfunction

    task automatic end_test(input string name);
        tests++;
        $display("test %s finished with %0d errors", name, errors - errors_before);
        errors_before = errors;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test sequence.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        tlb_entry_t  e;
        tlb_result_t exp;
        logic [19:0] vpn;
        logic [11:0] off;
        int          idx;
        int          n;
        seed = 32'h1a890d7b;
        errors = 0;
        checks = 0;
        tests = 0;
        errors_before = 0;
        rst_n = 1'b0;
        cmd_valid = 1'b0;
        cmd = '0;
        data_start = 1'b0;
        data_vaddr = '0;
        data_store = 1'b0;
        fetch_start = 1'b0;
        fetch_vaddr = '0;
        model_random = 6'd63;
        model_asid = '0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        tick();

        // Write and read back.
        for (int i = 0; i < 84; i++) begin
            idx = (i < 64) ? i : ($random(seed) & 63);
            gen_entry(idx, e);
            if (idx == 5)
                e.g = 1'b0;  // Kept non-global for the ASID probe.
            model[idx] = e;
            send_cmd(tlb_write_indexed, idx, e);
        end
        for (int i = 0; i < 64; i++)
            read_check("write_read", i);
        end_test("write_read");

        // Random replacement walks down and wraps.
        for (int i = 0; i < 60; i++) begin
            idx = int'(model_random);
            gen_entry(idx, e);
            if (idx == 5)
                e.g = 1'b0;
            model[idx] = e;
            send_cmd(tlb_write_random, 0, e);
            model_random = (model_random == 6'(random_low)) ? 6'd63 : model_random - 6'd1;
            read_check("random_write", idx);
        end
        end_test("random_write");

        // Probe hits, ASID mismatch, unused vpn.
        for (int i = 0; i < 8; i++) begin
            idx = $random(seed) & 63;
            probe_check(model[idx].vpn, model[idx].asid, 1'b1, idx);
        end
        probe_check(model[5].vpn, model[5].asid ^ 6'h20, 1'b0, 0);
        probe_check({1'b1, 19'h5a5a5}, 6'd1, 1'b0, 0);
        end_test("probe");

        // Data translation.
        for (int i = 0; i < 40; i++) begin
            if (($random(seed) & 7) == 0) begin
                e = '0;
                e.asid = 6'($random(seed) & 3);
                model_asid = e.asid;
                send_cmd(tlb_set_asid, 0, e);
            end
            vpn = pick_vpn($random(seed) & 32'h7fffffff);
            off = 12'($random(seed));
            data_vaddr = {vpn, off};
            data_store = 1'($random(seed) & 1);
            exp = expect_result(vpn, off, data_store);
            data_start = 1'b1;
            tick();
            data_start = 1'b0;
            n = 0;
            while (!data_done) begin
                if (n >= timeout)
                    abort_timeout("data_done");
                tick();
                n++;
            end
            compare("data_lookup", 64'(exp), 64'(data_result));
        end
        end_test("data_lookup");

        // Fetch with reads and rewrites issued alongside.
        for (int i = 0; i < 16; i++) begin
            vpn = pick_vpn($random(seed) & 32'h7fffffff);
            off = 12'($random(seed));
            fetch_vaddr = {vpn, off};
            exp = expect_result(vpn, off, 1'b0);
            fetch_start = 1'b1;
            tick();
            fetch_start = 1'b0;
            n = 0;
            while (!fetch_done) begin
                if (n >= timeout)
                    abort_timeout("fetch_done");
                idx = $random(seed) & 63;
                if (n < 8) begin
                    cmd_valid = 1'b1;
                    cmd.index = 6'(idx);
                    cmd.op    = n[0] ? tlb_write_indexed : tlb_read;
                    cmd.entry = model[idx];  // Rewrite leaves contents unchanged.
                end
                tick();
                if (cmd_valid && cmd.op == tlb_read) begin
                    compare("fetch read_valid", 64'(1), 64'(read_valid));
                    compare("fetch read", 64'(model[idx]), 64'(read_entry));
                end
                cmd_valid = 1'b0;
                cmd.op = tlb_nop;
                n++;
            end
            compare("fetch_lookup", 64'(exp), 64'(fetch_result));
        end
        end_test("fetch_lookup");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/mmu_tlb_chk.sv ====
// Bound checker with protocol and timing assertions for the MMU TLB top level.
`timescale 1ns/1ns
`default_nettype none

module mmu_tlb_chk import tlb_pkg::*; (
    input wire       clk,
    input wire       rst_n,
    input wire       cmd_valid,
    input wire       tlb_cmd_t cmd,
    input wire       busy,
    input wire       data_start,
    input wire       data_done,
    input wire       fetch_done,
    input wire       read_valid
);

    logic       pending;
    logic [3:0] since;  // Cycles from data_start to data_done.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
            since   <= '0;
        end else if (data_start) begin
            pending <= 1'b1;
            since   <= '0;
        end else if (data_done) begin
            pending <= 1'b0;
        end else if (pending && since != 4'hf) begin
            since <= since + 4'd1;
        end
    end

    a_no_cmd_busy : assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid |-> !busy) else $error("Command issued while busy.");

    a_done_known : assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown({data_done, fetch_done})) else $error("Done signal unknown.");

    a_data_window : assert property (@(posedge clk) disable iff (!rst_n)
        data_done |-> pending && since >= 4'd2 && since <= 4'd10)
        else $error("data_done outside its window.");

    a_data_late : assert property (@(posedge clk) disable iff (!rst_n)
        pending |-> since <= 4'd10) else $error("data_done missing.");

    a_read_latency : assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid && cmd.op == tlb_read |=> read_valid) else $error("read_valid late.");

endmodule

bind mmu_tlb_top mmu_tlb_chk u_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .busy       (busy),
    .data_start (data_start),
    .data_done  (data_done),
    .fetch_done (fetch_done),
    .read_valid (read_valid)
);

`default_nettype wire

// ==== source/mmu_tlb_top.sv ====
// MMU TLB top level joining command decode, entry storage and translation.
`timescale 1ns/1ns
`default_nettype none

module mmu_tlb_top import tlb_pkg::*; #(
    parameter int random_low = 8
) (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 cmd_valid,
    input  wire tlb_cmd_t       cmd,
    input  wire                 data_start,
    input  wire [31:0]          data_vaddr,
    input  wire                 data_store,
    input  wire                 fetch_start,
    input  wire [31:0]          fetch_vaddr,
    output logic                read_valid,
    output tlb_entry_t          read_entry,
    output logic                probe_done,
    output logic                probe_hit,
    output logic [index_w-1:0]  probe_index,
    output logic                busy,
    output logic                data_done,
    output tlb_result_t         data_result,
    output logic                fetch_done,
    output tlb_result_t         fetch_result
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Internal wiring.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic               ram_read_do;
    logic               ram_write_do;
    logic [index_w-1:0] ram_index;
    tlb_entry_t         ram_write_entry;
    logic [asid_w-1:0]  cur_asid;
    logic               search_start;
    logic [vpn_w-1:0]   search_vpn;
    logic               ram_read_ready;
    tlb_entry_t         ram_read_entry;
    logic               ram_data_hit;
    logic [index_w-1:0] ram_data_index;
    tlb_entry_t         ram_data_entry;
    logic               ram_data_missed;
    logic               ram_fetch_hit;
    tlb_entry_t         ram_fetch_entry;
    logic               ram_fetch_missed;

    tlb_cmd_decode #(.random_low(random_low)) u_decode (
        .clk             (clk),
        .rst_n           (rst_n),
        .cmd_valid       (cmd_valid),
        .cmd             (cmd),
        .data_start      (data_start),
        .data_vpn        (data_vaddr[31:offset_w]),
        .ram_read_ready  (ram_read_ready),
        .ram_read_entry  (ram_read_entry),
        .ram_data_hit    (ram_data_hit),
        .ram_data_index  (ram_data_index),
        .ram_data_missed (ram_data_missed),
        .ram_read_do     (ram_read_do),
        .ram_write_do    (ram_write_do),
        .ram_index       (ram_index),
        .ram_write_entry (ram_write_entry),
        .cur_asid        (cur_asid),
        .search_start    (search_start),
        .search_vpn      (search_vpn),
        .read_valid      (read_valid),
        .read_entry      (read_entry),
        .probe_done      (probe_done),
        .probe_hit       (probe_hit),
        .probe_index     (probe_index),
        .busy            (busy)
    );

    tlb_ram u_ram (
        .clk          (clk),
        .rst_n        (rst_n),
        .read_do      (ram_read_do),
        .write_do     (ram_write_do),
        .index        (ram_index),
        .write_entry  (ram_write_entry),
        .cur_asid     (cur_asid),
        .data_start   (search_start),
        .data_vpn     (search_vpn),
        .fetch_start  (fetch_start),
        .fetch_vpn    (fetch_vaddr[31:offset_w]),
        .read_ready   (ram_read_ready),
        .read_entry   (ram_read_entry),
        .data_hit     (ram_data_hit),
        .data_index   (ram_data_index),
        .data_entry   (ram_data_entry),
        .data_missed  (ram_data_missed),
        .fetch_hit    (ram_fetch_hit),
        .fetch_entry  (ram_fetch_entry),
        .fetch_missed (ram_fetch_missed)
    );

    tlb_translate u_translate (
        .clk          (clk),
        .rst_n        (rst_n),
        .data_start   (data_start),
        .data_vaddr   (data_vaddr),
        .data_store   (data_store),
        .fetch_start  (fetch_start),
        .fetch_vaddr  (fetch_vaddr),
        .data_hit     (ram_data_hit),
        .data_entry   (ram_data_entry),
        .data_missed  (ram_data_missed),
        .fetch_hit    (ram_fetch_hit),
        .fetch_entry  (ram_fetch_entry),
        .fetch_missed (ram_fetch_missed),
        .data_done    (data_done),
        .data_result  (data_result),
        .fetch_done   (fetch_done),
        .fetch_result (fetch_result)
    );

endmodule

`default_nettype wire

// ==== source/tlb_translate.sv ====
// Data and fetch lookup tracking with physical address and exception forming.
`timescale 1ns/1ns
`default_nettype none

module tlb_translate import tlb_pkg::*; (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               data_start,
    input  wire [31:0]        data_vaddr,
    input  wire               data_store,
    input  wire               fetch_start,
    input  wire [31:0]        fetch_vaddr,
    input  wire               data_hit,
    input  wire tlb_entry_t   data_entry,
    input  wire               data_missed,
    input  wire               fetch_hit,
    input  wire tlb_entry_t   fetch_entry,
    input  wire               fetch_missed,
    output logic              data_done,
    output tlb_result_t       data_result,
    output logic              fetch_done,
    output tlb_result_t       fetch_result
);

    logic                data_pend_q;
    logic                fetch_pend_q;
    logic                store_q;
    logic [offset_w-1:0] data_off_q;
    logic [offset_w-1:0] fetch_off_q;

    // Outcome rules. Address fields are zero on an exception.
    function automatic tlb_result_t form_result(
        input logic                hit,
        input tlb_entry_t          entry,
        input logic [offset_w-1:0] offset,
        input logic                store
    );
        tlb_result_t r;
        r = '0;
        if (!hit)
            r.exc = exc_refill;
        else if (!entry.v)
            r.exc = exc_invalid;
        else if (store && !entry.d)
            r.exc = exc_modified;
        else begin
            r.exc      = exc_none;
            r.paddr    = {entry.pfn, offset};
            r.uncached = entry.n;
        end
        return r;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pending flags and done pulses.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_pend_q  <= 1'b0;
            fetch_pend_q <= 1'b0;
            data_done    <= 1'b0;
            fetch_done   <= 1'b0;
        end else begin
            data_done  <= data_pend_q && (data_hit || data_missed);  // Probes stay silent.
            fetch_done <= fetch_pend_q && (fetch_hit || fetch_missed);
            if (data_start)
                data_pend_q <= 1'b1;
            else if (data_hit || data_missed)
                data_pend_q <= 1'b0;
            if (fetch_start)
                fetch_pend_q <= 1'b1;
            else if (fetch_hit || fetch_missed)
                fetch_pend_q <= 1'b0;
        end
    end

    // Page offset and access kind, held for the search.
    always_ff @(posedge clk) begin
        if (data_start) begin
            data_off_q <= data_vaddr[offset_w-1:0];
            store_q    <= data_store;
        end
        if (fetch_start)
            fetch_off_q <= fetch_vaddr[offset_w-1:0];
    end

    always_ff @(posedge clk) begin
        if (data_pend_q && (data_hit || data_missed))
            data_result <= form_result(data_hit, data_entry, data_off_q, store_q);
        if (fetch_pend_q && (fetch_hit || fetch_missed))
            fetch_result <= form_result(fetch_hit, fetch_entry, fetch_off_q, 1'b0);
    end

endmodule

`default_nettype wire

// ==== source/tlb_cmd_decode.sv ====
// TLB command decoder with random index, ASID and probe state.
`timescale 1ns/1ns
`default_nettype none

module tlb_cmd_decode import tlb_pkg::*; #(
    parameter int random_low = 8
) (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    cmd_valid,
    input  wire tlb_cmd_t          cmd,
    input  wire                    data_start,
    input  wire [vpn_w-1:0]        data_vpn,
    input  wire                    ram_read_ready,
    input  wire tlb_entry_t        ram_read_entry,
    input  wire                    ram_data_hit,
    input  wire [index_w-1:0]      ram_data_index,
    input  wire                    ram_data_missed,
    output logic                   ram_read_do,
    output logic                   ram_write_do,
    output logic [index_w-1:0]     ram_index,
    output tlb_entry_t             ram_write_entry,
    output logic [asid_w-1:0]      cur_asid,
    output logic                   search_start,
    output logic [vpn_w-1:0]       search_vpn,
    output logic                   read_valid,
    output tlb_entry_t             read_entry,
    output logic                   probe_done,
    output logic                   probe_hit,
    output logic [index_w-1:0]     probe_index,
    output logic                   busy
);

    logic [index_w-1:0] random_q;
    logic               probe_cmd;
    logic               random_cmd;

    assign probe_cmd  = cmd_valid && cmd.op == tlb_probe;
    assign random_cmd = cmd_valid && cmd.op == tlb_write_random;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Opcode to RAM strobes, search port select.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        ram_read_do  = cmd_valid && cmd.op == tlb_read;
        ram_write_do = random_cmd || (cmd_valid && cmd.op == tlb_write_indexed);
        ram_index    = random_cmd ? random_q : cmd.index;
        search_start = probe_cmd || data_start;  // Probe owns the data port.
        search_vpn   = probe_cmd ? cmd.entry.vpn : data_vpn;
    end

    assign ram_write_entry = cmd.entry;
    assign read_valid      = ram_read_ready;
    assign read_entry      = ram_read_entry;

    // Steps down per random write, wraps to the top.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            random_q <= '1;
        end else if (random_cmd) begin
            if (random_q == index_w'(random_low))
                random_q <= '1;
            else
                random_q <= random_q - 1'b1;
        end
    end

    // Probe and set_asid both load the ASID.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_asid <= '0;
        end else if (cmd_valid && (cmd.op == tlb_set_asid || cmd.op == tlb_probe)) begin
            cur_asid <= cmd.entry.asid;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Probe tracking.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            probe_done <= 1'b0;
        end else begin
            probe_done <= busy && (ram_data_hit || ram_data_missed);
            if (probe_cmd)
                busy <= 1'b1;
            else if (ram_data_hit || ram_data_missed)
                busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            probe_hit   <= ram_data_hit;
            probe_index <= ram_data_index;
        end
    end

endmodule

`default_nettype wire

// ==== tlb/tlb_ram.sv ====
// 64-entry TLB storage with rotating eight-wide search for the data and fetch ports.
`timescale 1ns/1ns
`default_nettype none

module tlb_ram import tlb_pkg::*; (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    read_do,
    input  wire                    write_do,
    input  wire [index_w-1:0]      index,
    input  wire tlb_entry_t        write_entry,
    input  wire [asid_w-1:0]       cur_asid,
    input  wire                    data_start,
    input  wire [vpn_w-1:0]        data_vpn,
    input  wire                    fetch_start,
    input  wire [vpn_w-1:0]        fetch_vpn,
    output logic                   read_ready,
    output tlb_entry_t             read_entry,
    output logic                   data_hit,
    output logic [index_w-1:0]     data_index,
    output tlb_entry_t             data_entry,
    output logic                   data_missed,
    output logic                   fetch_hit,
    output tlb_entry_t             fetch_entry,
    output logic                   fetch_missed
);

    logic       access_q;         // Outputs held a read or write row.
    logic [2:0] row_q;
    logic [2:0] row_next;
    logic [2:0] addr_row;
    logic [2:0] read_col_q;
    tlb_entry_t q [8];            // Current row, column order.

    logic [vpn_w-1:0] data_vpn_q;
    logic [vpn_w-1:0] fetch_vpn_q;
    logic [3:0]       data_cnt_q;
    logic [3:0]       fetch_cnt_q;
    logic [7:0]       data_match;
    logic [7:0]       fetch_match;
    logic [2:0]       data_col;
    logic [2:0]       fetch_col;
    logic             data_hit_next;
    logic             fetch_hit_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Row pointer and read port.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign row_next = (read_do || write_do) ? row_q : row_q + 3'd1;
    assign addr_row = (read_do || write_do) ? index[5:3] : row_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_q      <= '0;
            access_q   <= 1'b0;
            read_ready <= 1'b0;
        end else begin
            row_q      <= row_next;
            access_q   <= read_do || write_do;
            read_ready <= read_do;
        end
    end

    always_ff @(posedge clk) begin
        if (read_do)
            read_col_q <= index[2:0];
    end

    assign read_entry = q[read_col_q];

    // Four banks, two columns each. Port a in lower half, port b upper.
    for (genvar b = 0; b < 4; b++) begin : g_bank
        tlb_dual_ram #(
            .width  ($bits(tlb_entry_t)),
            .addr_w (4)
        ) u_ram (
            .clk       (clk),
            .address_a ({1'b0, addr_row}),
            .wren_a    (write_do && index[2:0] == 3'(2 * b)),
            .data_a    (write_entry),
            .q_a       (q[2 * b]),
            .address_b ({1'b1, addr_row}),
            .wren_b    (write_do && index[2:0] == 3'(2 * b + 1)),
            .data_b    (write_entry),
            .q_b       (q[2 * b + 1])
        );
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Associative compare of the current row.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        data_col  = '0;
        fetch_col = '0;
        for (int i = 0; i < 8; i++) begin
            data_match[i]  = q[i].vpn == data_vpn_q && (q[i].g || q[i].asid == cur_asid);
            fetch_match[i] = q[i].vpn == fetch_vpn_q && (q[i].g || q[i].asid == cur_asid);
        end
        for (int i = 7; i >= 0; i--) begin
            if (data_match[i])
                data_col = 3'(i);  // Lowest column wins.
            if (fetch_match[i])
                fetch_col = 3'(i);
        end
    end

    assign data_hit_next  = data_cnt_q != 4'd0 && |data_match;
    assign fetch_hit_next = fetch_cnt_q != 4'd0 && !access_q && |fetch_match;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_hit  <= 1'b0;
            fetch_hit <= 1'b0;
        end else begin
            data_hit  <= data_hit_next;
            fetch_hit <= fetch_hit_next;
        end
    end

    always_ff @(posedge clk) begin
        data_index  <= {row_q, data_col};
        data_entry  <= q[data_col];
        fetch_entry <= q[fetch_col];
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Search counters, eight rows then give up.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (data_start)
            data_vpn_q <= data_vpn;
        if (fetch_start)
            fetch_vpn_q <= fetch_vpn;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            data_cnt_q <= '0;
        else if (data_start)
            data_cnt_q <= 4'd1;
        else if (data_hit || data_cnt_q == 4'd9)
            data_cnt_q <= '0;
        else if (data_cnt_q != 4'd0)
            data_cnt_q <= data_cnt_q + 4'd1;
    end

    // Fetch stalls while the row outputs are stale.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            fetch_cnt_q <= '0;
        else if (fetch_start)
            fetch_cnt_q <= 4'd1;
        else if (fetch_hit || fetch_cnt_q == 4'd9)
            fetch_cnt_q <= '0;
        else if (fetch_cnt_q != 4'd0 && !access_q)
            fetch_cnt_q <= fetch_cnt_q + 4'd1;
    end

    assign data_missed  = data_cnt_q == 4'd9 && !data_hit;
    assign fetch_missed = fetch_cnt_q == 4'd9 && !fetch_hit;

endmodule

`default_nettype wire

// ==== tlb/tlb_dual_ram.sv ====
// Two-port synchronous RAM with registered read outputs.
`timescale 1ns/1ns
`default_nettype none

module tlb_dual_ram #(
    parameter int width  = 50,
    parameter int addr_w = 4
) (
    input  wire              clk,
    input  wire [addr_w-1:0] address_a,
    input  wire              wren_a,
    input  wire [width-1:0]  data_a,
    output logic [width-1:0] q_a,
    input  wire [addr_w-1:0] address_b,
    input  wire              wren_b,
    input  wire [width-1:0]  data_b,
    output logic [width-1:0] q_b
);

    logic [width-1:0] mem [2**addr_w];

    // Read returns old contents on a write.
    always_ff @(posedge clk) begin
        if (wren_a)
            mem[address_a] <= data_a;
        if (wren_b)
            mem[address_b] <= data_b;
        q_a <= mem[address_a];
        q_b <= mem[address_b];
    end

endmodule

`default_nettype wire

// ==== common/tlb_pkg.sv ====
// TLB field widths, entry layout, command and exception encodings, command and result types.
`default_nettype none

package tlb_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Field widths.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int vpn_w    = 20;
    localparam int pfn_w    = 20;
    localparam int asid_w   = 6;
    localparam int index_w  = 6;  // 64 entries.
    localparam int offset_w = 12; // 4 KiB pages.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One TLB entry, 50 bits.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic              g;    // Global, ignores ASID.
        logic              v;    // Valid.
        logic              d;    // Dirty, write enabled.
        logic              n;    // Noncachable.
        logic [asid_w-1:0] asid;
        logic [pfn_w-1:0]  pfn;
        logic [vpn_w-1:0]  vpn;
    } tlb_entry_t;

    // Coprocessor-0 style commands.
    typedef enum logic [2:0] {
        tlb_nop,
        tlb_read,
        tlb_write_indexed,
        tlb_write_random,
        tlb_probe,
        tlb_set_asid
    } tlb_cmd_e;

    // Entry field doubles as probe key and new ASID.
    typedef struct packed {
        tlb_cmd_e           op;
        logic [index_w-1:0] index;
        tlb_entry_t         entry;
    } tlb_cmd_t;

    typedef enum logic [1:0] {
        exc_none,
        exc_refill,
        exc_invalid,
        exc_modified
    } tlb_exc_e;

    // Outcome of one translation.
    typedef struct packed {
        logic [31:0] paddr;
        logic        uncached;
        tlb_exc_e    exc;
    } tlb_result_t;

endpackage

`default_nettype wire
